// ==== verilog/mini_src_settings.svh ====
`ifndef MINI_SRC_SETTINGS_SVH
`define MINI_SRC_SETTINGS_SVH

// datapath word width
`define MS_DATA_WIDTH 32

// general register file
`define MS_NUM_REGS 16
`define MS_REG_BITS 4

// constant field of the instruction word
`define MS_CONST_BITS 19

`endif

// ==== verilog/isa_pkg.sv ====
`default_nettype none

`include "mini_src_settings.svh"

package isa_pkg;

	// opcode numbering of the teaching instruction set
	typedef enum logic [4:0] {
		OP_LD   = 5'd0,
		OP_LDI  = 5'd1,
		OP_ST   = 5'd2,
		OP_ADD  = 5'd3,
		OP_SUB  = 5'd4,
		OP_SHR  = 5'd5,
		OP_SHRA = 5'd6,
		OP_SHL  = 5'd7,
		OP_ROR  = 5'd8,
		OP_ROL  = 5'd9,
		OP_AND  = 5'd10,
		OP_OR   = 5'd11,
		OP_ADDI = 5'd12,
		OP_ANDI = 5'd13,
		OP_ORI  = 5'd14,
		OP_MUL  = 5'd15,
		OP_DIV  = 5'd16,
		OP_NEG  = 5'd17,
		OP_NOT  = 5'd18,
		OP_MFHI = 5'd24,
		OP_MFLO = 5'd25
	} opcode_e;

	// instruction word, op in the top bits
	// rc shares bits with the constant: the 19-bit constant is {rc, imm}
	typedef struct packed {
		opcode_e                                op;
		logic [`MS_REG_BITS-1:0]                ra;
		logic [`MS_REG_BITS-1:0]                rb;
		logic [`MS_REG_BITS-1:0]                rc;
		logic [`MS_CONST_BITS-`MS_REG_BITS-1:0] imm;
	} instr_t;

endpackage

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

`include "mini_src_settings.svh"

package pipe_pkg;

	import isa_pkg::*;

	// decode to execute
	typedef struct packed {
		opcode_e                   op;
		logic [`MS_REG_BITS-1:0]   dst;
		logic [`MS_DATA_WIDTH-1:0] a;
		logic [`MS_DATA_WIDTH-1:0] b;
		logic [`MS_DATA_WIDTH-1:0] imm;
		logic                      use_imm;
		logic                      wr_gpr;
	} dec_t;

	// execute to result
	typedef struct packed {
		logic [`MS_REG_BITS-1:0]   dst;
		logic [`MS_DATA_WIDTH-1:0] value;
		logic                      wr_gpr;
		logic                      wr_hilo;
		logic [`MS_DATA_WIDTH-1:0] hi;
		logic [`MS_DATA_WIDTH-1:0] lo;
	} exe_t;

	// retired instruction as seen at the output
	typedef struct packed {
		logic [`MS_REG_BITS-1:0]   dst;
		logic [`MS_DATA_WIDTH-1:0] value;
		logic                      wr_gpr;
		logic                      wr_hilo;
		logic [`MS_DATA_WIDTH-1:0] hi;
		logic [`MS_DATA_WIDTH-1:0] lo;
	} wb_t;

	// bypass tap, valid only for a general register write
	typedef struct packed {
		logic                      valid;
		logic [`MS_REG_BITS-1:0]   dst;
		logic [`MS_DATA_WIDTH-1:0] value;
	} fwd_t;

endpackage

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mini_src_settings.svh"

module reg_file (
	input  wire                        clk,
	input  wire                        rst,
	input  wire  [`MS_REG_BITS-1:0]    rd_a_idx,
	input  wire  [`MS_REG_BITS-1:0]    rd_b_idx,
	output logic [`MS_DATA_WIDTH-1:0]  rd_a_data,
	output logic [`MS_DATA_WIDTH-1:0]  rd_b_data,
	input  wire                        wr_en,
	input  wire  [`MS_REG_BITS-1:0]    wr_idx,
	input  wire  [`MS_DATA_WIDTH-1:0]  wr_data
);

	logic [`MS_DATA_WIDTH-1:0] regs [`MS_NUM_REGS];

	// asynchronous reads, r0 is an ordinary register here
	assign rd_a_data = regs[rd_a_idx];
	assign rd_b_data = regs[rd_b_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mini_src_settings.svh"

module instr_decode import isa_pkg::*, pipe_pkg::*; (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        instr_valid,
	input  wire  instr_t               instr,
	output logic [`MS_REG_BITS-1:0]    rd_a_idx,
	output logic [`MS_REG_BITS-1:0]    rd_b_idx,
	input  wire  [`MS_DATA_WIDTH-1:0]  rd_a_data,
	input  wire  [`MS_DATA_WIDTH-1:0]  rd_b_data,
	input  wire  fwd_t                 exe_fwd,
	input  wire  fwd_t                 res_fwd,
	output logic                       dec_valid,
	output dec_t                       dec
);

	localparam int W   = `MS_DATA_WIDTH;
	localparam int EXT = `MS_DATA_WIDTH - `MS_CONST_BITS;

	logic [`MS_CONST_BITS-1:0] const_field;
	logic                      zero_base;
	dec_t                      dec_next;

	// newest producer wins, then the older one, then the register file
	function automatic logic [W-1:0] bypass(
		input logic [`MS_REG_BITS-1:0] idx,
		input logic [W-1:0]            rf_data,
		input fwd_t                    near,
		input fwd_t                    far
	);
		if (near.valid && near.dst == idx) begin
			return near.value;
		end else if (far.valid && far.dst == idx) begin
			return far.value;
		end
		return rf_data;
	endfunction

	// rb feeds operand a, rc feeds operand b
	assign rd_a_idx = instr.rb;
	assign rd_b_idx = instr.rc;

	assign const_field = {instr.rc, instr.imm};
	// ldi and addi take r0 as a zero base
	assign zero_base = (instr.op == OP_LDI || instr.op == OP_ADDI) && instr.rb == '0;

	always_comb begin
		dec_next.op      = instr.op;
		dec_next.dst     = instr.ra;
		dec_next.a       = zero_base ? '0 : bypass(instr.rb, rd_a_data, exe_fwd, res_fwd);
		dec_next.b       = bypass(instr.rc, rd_b_data, exe_fwd, res_fwd);
		dec_next.imm     = {{EXT{const_field[`MS_CONST_BITS-1]}}, const_field};
		dec_next.use_imm = 1'b0;
		dec_next.wr_gpr  = 1'b0;
		case (instr.op)
			OP_LDI, OP_ADDI, OP_ANDI, OP_ORI: begin
				dec_next.use_imm = 1'b1;
				dec_next.wr_gpr  = 1'b1;
			end
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NEG, OP_NOT,
			OP_SHR, OP_SHRA, OP_SHL, OP_ROR, OP_ROL,
			OP_MFHI, OP_MFLO: begin
				dec_next.wr_gpr = 1'b1;
			end
			// mul only lands in hi/lo; unsupported ops retire with no write
			default: begin
				dec_next.wr_gpr = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec <= dec_next;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mini_src_settings.svh"

module alu_execute import isa_pkg::*, pipe_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	input  wire         dec_valid,
	input  wire  dec_t  dec,
	output fwd_t        exe_fwd,
	output logic        exe_valid,
	output exe_t        exe
);

	localparam int W  = `MS_DATA_WIDTH;
	localparam int SH = $clog2(`MS_DATA_WIDTH);

	logic [W-1:0]   opnd_b;
	logic [SH-1:0]  amount;
	logic [2*W-1:0] product;
	logic [2*W-1:0] ror_word;
	logic [2*W-1:0] rol_word;
	logic [W-1:0]   hi_q;
	logic [W-1:0]   lo_q;
	logic [W-1:0]   result;
	logic           is_mul;

	assign opnd_b = dec.use_imm ? dec.imm : dec.b;
	// shift amount is the low bits of the rc operand
	assign amount = dec.b[SH-1:0];
	assign is_mul = dec.op == OP_MUL;

	// signed 32x32, full 64-bit product
	assign product = $signed(dec.a) * $signed(dec.b);

	// rotate by shifting the word next to a copy of itself
	assign ror_word = {dec.a, dec.a} >> amount;
	assign rol_word = {dec.a, dec.a} << amount;

	always_comb begin
		case (dec.op)
			OP_ADD, OP_ADDI, OP_LDI: result = dec.a + opnd_b;
			OP_SUB:                  result = dec.a - opnd_b;
			OP_AND, OP_ANDI:         result = dec.a & opnd_b;
			OP_OR, OP_ORI:           result = dec.a | opnd_b;
			OP_SHR:                  result = dec.a >> amount;
			OP_SHRA:                 result = $signed(dec.a) >>> amount;
			OP_SHL:                  result = dec.a << amount;
			OP_ROR:                  result = ror_word[W-1:0];
			OP_ROL:                  result = rol_word[2*W-1:W];
			OP_NEG:                  result = -dec.a;
			OP_NOT:                  result = ~dec.a;
			OP_MUL:                  result = product[W-1:0];
			OP_MFHI:                 result = hi_q;
			OP_MFLO:                 result = lo_q;
			default:                 result = '0;
		endcase
	end

	// tap for the instruction now in decode
	assign exe_fwd.valid = dec_valid && dec.wr_gpr;
	assign exe_fwd.dst   = dec.dst;
	assign exe_fwd.value = result;

	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (dec_valid && is_mul) begin
			hi_q <= product[2*W-1:W];
			lo_q <= product[W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
		end
	end

	// non-mul instructions carry the current hi/lo along
	always_ff @(posedge clk) begin
		exe.dst     <= dec.dst;
		exe.value   <= result;
		exe.wr_gpr  <= dec.wr_gpr;
		exe.wr_hilo <= is_mul;
		exe.hi      <= is_mul ? product[2*W-1:W] : hi_q;
		exe.lo      <= is_mul ? product[W-1:0] : lo_q;
	end

endmodule

`default_nettype wire

// ==== verilog/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mini_src_settings.svh"

module result_writeback import pipe_pkg::*; (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        exe_valid,
	input  wire  exe_t                 exe,
	output logic                       wr_en,
	output logic [`MS_REG_BITS-1:0]    wr_idx,
	output logic [`MS_DATA_WIDTH-1:0]  wr_data,
	output fwd_t                       res_fwd,
	output logic                       wb_valid,
	output wb_t                        wb
);

	// register write lands on the same edge as the output strobe
	assign wr_en   = exe_valid && exe.wr_gpr;
	assign wr_idx  = exe.dst;
	assign wr_data = exe.value;

	// same write, seen by decode one cycle before the file has it
	assign res_fwd.valid = wr_en;
	assign res_fwd.dst   = exe.dst;
	assign res_fwd.value = exe.value;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (exe_valid) begin
			wb.dst     <= exe.dst;
			wb.value   <= exe.value;
			wb.wr_gpr  <= exe.wr_gpr;
			wb.wr_hilo <= exe.wr_hilo;
			wb.hi      <= exe.hi;
			wb.lo      <= exe.lo;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mini_src_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mini_src_settings.svh"

module mini_src_top import isa_pkg::*, pipe_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire          instr_valid,
	input  wire  instr_t instr,
	output logic         wb_valid,
	output wb_t          wb
);

	logic [`MS_REG_BITS-1:0]   rd_a_idx;
	logic [`MS_REG_BITS-1:0]   rd_b_idx;
	logic [`MS_DATA_WIDTH-1:0] rd_a_data;
	logic [`MS_DATA_WIDTH-1:0] rd_b_data;
	logic                      wr_en;
	logic [`MS_REG_BITS-1:0]   wr_idx;
	logic [`MS_DATA_WIDTH-1:0] wr_data;
	fwd_t                      exe_fwd;
	fwd_t                      res_fwd;
	logic                      dec_valid;
	dec_t                      dec;
	logic                      exe_valid;
	exe_t                      exe;

	reg_file u_reg_file (
		.clk       (clk),
		.rst       (rst),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data)
	);

	// decode, fed by both bypass taps
	instr_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rd_a_idx    (rd_a_idx),
		.rd_b_idx    (rd_b_idx),
		.rd_a_data   (rd_a_data),
		.rd_b_data   (rd_b_data),
		.exe_fwd     (exe_fwd),
		.res_fwd     (res_fwd),
		.dec_valid   (dec_valid),
		.dec         (dec)
	);

	alu_execute u_execute (
		.clk       (clk),
		.rst       (rst),
		.dec_valid (dec_valid),
		.dec       (dec),
		.exe_fwd   (exe_fwd),
		.exe_valid (exe_valid),
		.exe       (exe)
	);

	result_writeback u_result (
		.clk       (clk),
		.rst       (rst),
		.exe_valid (exe_valid),
		.exe       (exe),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.res_fwd   (res_fwd),
		.wb_valid  (wb_valid),
		.wb        (wb)
	);

endmodule

`default_nettype wire

// ==== tb/mini_src_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mini_src_settings.svh"

module mini_src_tb import isa_pkg::*, pipe_pkg::*; ();

	localparam int MAX_ROWS   = 128;
	localparam int LATENCY    = 3;
	localparam int WAIT_LIMIT = 40;
	localparam int W          = `MS_DATA_WIDTH;

	typedef logic [`MS_REG_BITS-1:0]   idx_t;
	typedef logic [`MS_CONST_BITS-1:0] const_t;

	// table row with instruction, idle cycles before it and expected retire fields
	typedef struct packed {
		instr_t       w;
		logic [31:0]  gap;
		logic [W-1:0] value;
		logic         gpr;
		logic         hilo;
		logic [W-1:0] hi;
		logic [W-1:0] lo;
	} row_t;

	logic   clk;
	logic   rst;
	logic   instr_valid;
	instr_t instr;
	logic   wb_valid;
	wb_t    wb;

	row_t rows [MAX_ROWS];
	int   row_cnt = 0;
	int   issue_cyc [$];
	int   cyc = 0;
	int   checked = 0;

	mini_src_top uut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb          (wb)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// rising edges since time zero
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic instr_t reg_op(input opcode_e op, input int ra, input int rb, input int rc);
		instr_t w;
		w.op  = op;
		w.ra  = idx_t'(ra);
		w.rb  = idx_t'(rb);
		w.rc  = idx_t'(rc);
		w.imm = '0;
		return w;
	endfunction

	// constant spans the rc field and the low bits
	function automatic instr_t imm_op(input opcode_e op, input int ra, input int rb, input int c);
		instr_t w;
		w.op = op;
		w.ra = idx_t'(ra);
		w.rb = idx_t'(rb);
		{w.rc, w.imm} = const_t'(c);
		return w;
	endfunction

	task automatic add_row(input instr_t w, input int gap, input logic [W-1:0] value);
		row_t r;
		r       = '0;
		r.w     = w;
		r.gap   = gap;
		r.value = value;
		r.gpr   = 1'b1;
		rows[row_cnt] = r;
		row_cnt++;
	endtask

	task automatic add_mul_row(input instr_t w, input int gap, input logic [W-1:0] hi,
			input logic [W-1:0] lo);
		row_t r;
		r      = '0;
		r.w    = w;
		r.gap  = gap;
		r.hilo = 1'b1;
		r.hi   = hi;
		r.lo   = lo;
		rows[row_cnt] = r;
		row_cnt++;
	endtask

	// fill every register the dependent sequence reads so a stale read shows up
	task automatic scrub_regs();
		add_row(imm_op(OP_LDI, 1, 0, 'h55), 3, 32'h0000_0055);
		add_row(imm_op(OP_LDI, 2, 0, 'h55), 0, 32'h0000_0055);
		add_row(imm_op(OP_LDI, 3, 0, 'h55), 0, 32'h0000_0055);
		add_row(imm_op(OP_LDI, 4, 0, 'h55), 0, 32'h0000_0055);
		add_row(imm_op(OP_LDI, 5, 0, 'h55), 0, 32'h0000_0055);
		add_row(imm_op(OP_LDI, 7, 0, 'h55), 0, 32'h0000_0055);
	endtask

	// same expected values whatever the spacing
	task automatic dependent_seq(input int gap);
		add_row(imm_op(OP_LDI, 1, 0, 7), 3, 32'h0000_0007);
		add_row(reg_op(OP_ADD, 2, 1, 1), gap, 32'h0000_000E);
		add_row(reg_op(OP_SUB, 3, 2, 1), gap, 32'h0000_0007);
		add_row(reg_op(OP_SHL, 4, 3, 1), gap, 32'h0000_0380);
		add_row(imm_op(OP_ADDI, 5, 4, -1), gap, 32'h0000_037F);
		add_row(reg_op(OP_NEG, 6, 5, 0), gap, 32'hFFFF_FC81);
		// newer of two r7 writes in flight must win
		add_row(imm_op(OP_LDI, 7, 0, 1), gap, 32'h0000_0001);
		add_row(imm_op(OP_LDI, 7, 0, 2), gap, 32'h0000_0002);
		add_row(reg_op(OP_ADD, 8, 7, 7), gap, 32'h0000_0004);
	endtask

	task automatic build_table();
		// r0 holds a nonzero value from here on
		add_row(imm_op(OP_LDI, 0, 0, 9), 3, 32'h0000_0009);
		// ldi with an r0 base gives the constant alone
		add_row(imm_op(OP_LDI, 1, 0, 5), 0, 32'h0000_0005);
		add_row(imm_op(OP_LDI, 2, 0, -3), 3, 32'hFFFF_FFFD);
		add_row(imm_op(OP_LDI, 3, 0, 262143), 3, 32'h0003_FFFF);
		add_row(imm_op(OP_LDI, 4, 0, -262144), 3, 32'hFFFC_0000);
		add_row(imm_op(OP_LDI, 5, 1, 10), 3, 32'h0000_000F);
		// register and immediate arithmetic
		add_row(reg_op(OP_ADD, 6, 1, 2), 3, 32'h0000_0002);
		add_row(reg_op(OP_SUB, 7, 1, 2), 3, 32'h0000_0008);
		add_row(reg_op(OP_AND, 8, 2, 3), 3, 32'h0003_FFFD);
		add_row(reg_op(OP_OR, 9, 1, 4), 3, 32'hFFFC_0005);
		add_row(reg_op(OP_NEG, 10, 2, 0), 3, 32'h0000_0003);
		add_row(reg_op(OP_NOT, 11, 1, 0), 3, 32'hFFFF_FFFA);
		add_row(imm_op(OP_ADDI, 12, 1, -7), 3, 32'hFFFF_FFFE);
		add_row(imm_op(OP_ANDI, 13, 2, 'hFF0), 3, 32'h0000_0FF0);
		add_row(imm_op(OP_ANDI, 13, 3, -16), 3, 32'h0003_FFF0);
		add_row(imm_op(OP_ORI, 14, 1, 'h100), 3, 32'h0000_0105);
		add_row(imm_op(OP_ADDI, 15, 0, 100), 3, 32'h0000_0064);
		// shift amounts 0, 1, 31 and 35 in r12..r15 with r9 as source
		add_row(imm_op(OP_LDI, 12, 0, 0), 3, 32'h0000_0000);
		add_row(imm_op(OP_LDI, 13, 0, 1), 3, 32'h0000_0001);
		add_row(imm_op(OP_LDI, 14, 0, 31), 3, 32'h0000_001F);
		add_row(imm_op(OP_LDI, 15, 0, 35), 3, 32'h0000_0023);
		add_row(reg_op(OP_SHR, 10, 9, 12), 3, 32'hFFFC_0005);
		add_row(reg_op(OP_SHR, 10, 9, 13), 3, 32'h7FFE_0002);
		add_row(reg_op(OP_SHR, 10, 9, 14), 3, 32'h0000_0001);
		add_row(reg_op(OP_SHR, 10, 9, 15), 3, 32'h1FFF_8000);
		add_row(reg_op(OP_SHRA, 10, 9, 12), 3, 32'hFFFC_0005);
		add_row(reg_op(OP_SHRA, 10, 9, 13), 3, 32'hFFFE_0002);
		add_row(reg_op(OP_SHRA, 10, 9, 14), 3, 32'hFFFF_FFFF);
		add_row(reg_op(OP_SHRA, 10, 9, 15), 3, 32'hFFFF_8000);
		add_row(reg_op(OP_SHRA, 10, 3, 13), 3, 32'h0001_FFFF);
		add_row(reg_op(OP_SHL, 10, 9, 12), 3, 32'hFFFC_0005);
		add_row(reg_op(OP_SHL, 10, 9, 13), 3, 32'hFFF8_000A);
		add_row(reg_op(OP_SHL, 10, 9, 14), 3, 32'h8000_0000);
		add_row(reg_op(OP_SHL, 10, 9, 15), 3, 32'hFFE0_0028);
		add_row(reg_op(OP_ROR, 10, 9, 12), 3, 32'hFFFC_0005);
		add_row(reg_op(OP_ROR, 10, 9, 13), 3, 32'hFFFE_0002);
		add_row(reg_op(OP_ROR, 10, 9, 14), 3, 32'hFFF8_000B);
		add_row(reg_op(OP_ROR, 10, 9, 15), 3, 32'hBFFF_8000);
		add_row(reg_op(OP_ROL, 10, 9, 12), 3, 32'hFFFC_0005);
		add_row(reg_op(OP_ROL, 10, 9, 13), 3, 32'hFFF8_000B);
		add_row(reg_op(OP_ROL, 10, 9, 14), 3, 32'hFFFE_0002);
		add_row(reg_op(OP_ROL, 10, 9, 15), 3, 32'hFFE0_002F);
		// wide gaps first, then back-to-back, then one idle cycle
		dependent_seq(3);
		scrub_regs();
		dependent_seq(0);
		scrub_regs();
		dependent_seq(1);
		// mul with hi/lo read right behind it
		add_row(imm_op(OP_LDI, 3, 0, 262143), 3, 32'h0003_FFFF);
		add_row(imm_op(OP_LDI, 4, 0, -262144), 0, 32'hFFFC_0000);
		add_mul_row(reg_op(OP_MUL, 5, 3, 4), 0, 32'hFFFF_FFF0, 32'h0004_0000);
		add_row(reg_op(OP_MFHI, 6, 0, 0), 0, 32'hFFFF_FFF0);
		add_row(reg_op(OP_MFLO, 7, 0, 0), 0, 32'h0004_0000);
		add_row(imm_op(OP_LDI, 1, 0, -6), 3, 32'hFFFF_FFFA);
		add_row(imm_op(OP_LDI, 2, 0, 7), 0, 32'h0000_0007);
		add_mul_row(reg_op(OP_MUL, 11, 1, 2), 0, 32'hFFFF_FFFF, 32'hFFFF_FFD6);
		add_row(reg_op(OP_MFLO, 8, 0, 0), 0, 32'hFFFF_FFD6);
		add_row(reg_op(OP_MFHI, 9, 0, 0), 0, 32'hFFFF_FFFF);
		// r5 untouched by the mul plus r0 as a plain operand
		add_row(reg_op(OP_ADD, 10, 5, 0), 0, 32'h0000_0388);
	endtask

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string what);
		stop_run($sformatf("error at %0t ns: %s", $time, what));
	endtask

	task automatic check_wb(input int i);
		row_t r;
		int   issued;
		r = rows[i];
		assert (issue_cyc.size() > 0)
			else stop_run("write-back strobe seen with no instruction issued");
		issued = issue_cyc.pop_front();
		assert (cyc == issued + LATENCY)
			else value_error($sformatf("row %0d retired after %0d cycles", i, cyc - issued));
		assert (wb.dst == r.w.ra)
			else value_error($sformatf("row %0d dst %0d, expected %0d", i, wb.dst, r.w.ra));
		assert (wb.wr_gpr == r.gpr)
			else value_error($sformatf("row %0d wr_gpr %b, expected %b", i, wb.wr_gpr, r.gpr));
		assert (wb.wr_hilo == r.hilo)
			else value_error($sformatf("row %0d wr_hilo %b, expected %b", i, wb.wr_hilo, r.hilo));
		if (r.hilo) begin
			assert (wb.hi == r.hi)
				else value_error($sformatf("row %0d hi %h, expected %h", i, wb.hi, r.hi));
			assert (wb.lo == r.lo)
				else value_error($sformatf("row %0d lo %h, expected %h", i, wb.lo, r.lo));
		end else begin
			assert (wb.value == r.value)
				else value_error($sformatf("row %0d value %h, expected %h", i, wb.value, r.value));
		end
	endtask

	// stimulus with one strobe per row on the falling edge
	initial begin
		int idle;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		build_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < row_cnt; i++) begin
			for (int g = 0; g < rows[i].gap; g++) begin
				instr_valid = 1'b0;
				@(negedge clk);
			end
			instr_valid = 1'b1;
			instr       = rows[i].w;
			issue_cyc.push_back(cyc);
			@(negedge clk);
		end
		instr_valid = 1'b0;
		idle = 0;
		while (checked < row_cnt) begin
			idle++;
			assert (idle < WAIT_LIMIT)
				else stop_run("not every instruction retired after the table ended");
			@(negedge clk);
		end
		// nothing more may retire
		for (int k = 0; k < 5; k++) begin
			@(negedge clk);
			assert (!wb_valid) else stop_run("write-back strobe after the last instruction");
		end
		$display("Finished with no errors");
		$finish;
	end

	// retire checker sampled on the falling edge
	initial begin
		int waited;
		waited = 0;
		@(posedge clk);
		while (rst) begin
			waited++;
			assert (waited < WAIT_LIMIT) else stop_run("reset was never released");
			@(posedge clk);
		end
		for (int i = 0; i < row_cnt; i++) begin
			waited = 0;
			@(negedge clk);
			while (!wb_valid) begin
				waited++;
				assert (waited < WAIT_LIMIT)
					else stop_run("timeout waiting for a write-back strobe");
				@(negedge clk);
			end
			check_wb(i);
			checked++;
		end
	end

endmodule

`default_nettype wire

// ==== mini_src.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_writeback.sv
verilog/mini_src_top.sv
tb/mini_src_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mini_src testbench with Verilator

LOG=sim.log
SIM=obj_dir/mini_src_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f mini_src.f --top-module mini_src_tb -Mdir obj_dir -o mini_src_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

if [ ! -x "$SIM" ]; then
	echo "simulation binary not found"
	exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation PASSED"
exit 0
